// File: hdl/mem_params.svh
// widths and depths for the load/store front end
// MEM_LINE_BYTES must equal MEM_LINE_W/8 and be a power of two
// MEM_CACHE_LINES and MEM_STORE_LINES must be powers of two
// line numbers beyond the store depth wrap onto lower lines

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// byte address and user data
`define MEM_ADDR_W 32
`define MEM_WORD_W 32

// one memory line
`define MEM_LINE_W 128
`define MEM_LINE_BYTES 16

// direct-mapped cache entries
`define MEM_CACHE_LINES 64

// backing store depth in lines
`define MEM_STORE_LINES 256

`endif

// File: hdl/mem_pkg.sv
// shared types of the load/store front end
// mem_ctrl_t follows the RISC-V funct3 layout with the unsigned flag above the size
// only SIZE_BYTE, SIZE_HALF and SIZE_WORD are legal sizes

`include "mem_params.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] addr_t;
    typedef logic [`MEM_WORD_W-1:0] word_t;
    typedef logic [`MEM_LINE_W-1:0] line_t;
    typedef logic [`MEM_ADDR_W-$clog2(`MEM_LINE_BYTES)-1:0] line_addr_t;
    typedef logic [`MEM_LINE_BYTES-1:0] line_mask_t;
    typedef logic [$clog2(`MEM_LINE_BYTES)-1:0] byte_off_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef struct packed {
        logic  is_unsigned;
        size_e size;
    } mem_ctrl_t;

    // one line beat from the sequencer to the cache
    typedef struct packed {
        logic       rd;
        logic       wr;
        line_addr_t addr;
        line_t      wdata;
        line_mask_t mask;
    } line_req_t;

    // what the aligner needs to build a load result
    typedef struct packed {
        byte_off_t off;
        mem_ctrl_t ctrl;
        logic      second;
    } load_ctx_t;

    typedef enum logic [2:0] {
        IDLE,
        RD_FIRST,
        RD_SECOND,
        WR_FIRST,
        WR_SECOND,
        DONE
    } seq_state_e;

endpackage

// File: hdl/access_sequencer.sv
// user-side access sequencer, one access in flight at a time
// a load needs a second line when offset plus size passes the line end
// a store is split into masked word beats, a second beat when it crosses a word
// o_busy is high from the cycle after acceptance until the DONE cycle ends

`timescale 1ns/1ps

`include "mem_params.svh"

module access_sequencer (
    input  logic               i_clk,
    input  logic               i_rrst_x,
    input  logic               i_rd_en,
    input  logic               i_wr_en,
    input  mem_pkg::addr_t     i_addr,
    input  mem_pkg::word_t     i_wdata,
    input  mem_pkg::mem_ctrl_t i_ctrl,
    input  logic               i_line_done,
    output logic               o_req_valid,
    output mem_pkg::line_req_t o_req,
    output mem_pkg::load_ctx_t o_ctx,
    output logic               o_cap_first,
    output logic               o_cap_second,
    output logic               o_busy
);
    import mem_pkg::*;

    seq_state_e                r_state;
    line_req_t                 r_req_next;
    logic                      r_two;
    logic                      w_accept;
    logic                      w_next_beat;
    logic [4:0]                w_end;
    word_t                     w_data_ext;
    logic [3:0]                w_mask_lo;
    logic [7:0]                w_mask_wide;
    logic [2*`MEM_WORD_W-1:0]  w_data_wide;
    logic [`MEM_ADDR_W-3:0]    w_word_addr;
    line_req_t                 w_beat0;
    line_req_t                 w_beat1;
    logic                      w_two;

    // place a word and its byte mask at the word's slot in the line
    function automatic line_req_t wr_beat(input logic [`MEM_ADDR_W-3:0] word_addr,
                                          input word_t data, input logic [3:0] mask);
        line_req_t req;
        req.rd    = 1'b0;
        req.wr    = 1'b1;
        req.addr  = word_addr[`MEM_ADDR_W-3:2];
        req.wdata = line_t'(data) << {word_addr[1:0], 5'b00000};
        req.mask  = line_mask_t'(mask) << {word_addr[1:0], 2'b00};
        return req;
    endfunction

    assign w_accept    = (i_rd_en || i_wr_en) && (r_state == IDLE);
    assign w_next_beat = i_line_done && r_two && (r_state == RD_FIRST || r_state == WR_FIRST);
    assign o_busy       = (r_state != IDLE);
    assign o_cap_first  = i_line_done && (r_state == RD_FIRST);
    assign o_cap_second = i_line_done && (r_state == RD_SECOND);

    always_comb begin
        w_end = {1'b0, i_addr[3:0]} + (5'd1 << i_ctrl.size);
        case (i_ctrl.size)
            SIZE_BYTE: begin
                w_data_ext = {24'h000000, i_wdata[7:0]};
                w_mask_lo  = 4'b0001;
            end
            SIZE_HALF: begin
                w_data_ext = {16'h0000, i_wdata[15:0]};
                w_mask_lo  = 4'b0011;
            end
            default: begin
                w_data_ext = i_wdata;
                w_mask_lo  = 4'b1111;
            end
        endcase
        // spill of the upper bytes lands in the next word
        w_mask_wide = {4'b0000, w_mask_lo} << i_addr[1:0];
        w_data_wide = {32'h0, w_data_ext} << {i_addr[1:0], 3'b000};
        w_word_addr = i_addr[`MEM_ADDR_W-1:2];
        if (i_rd_en) begin
            w_beat0      = '0;
            w_beat0.rd   = 1'b1;
            w_beat0.addr = i_addr[`MEM_ADDR_W-1:4];
            w_beat1      = w_beat0;
            w_beat1.addr = w_beat0.addr + 1'b1;
            w_two        = (w_end > 5'd16);
        end else begin
            w_beat0 = wr_beat(w_word_addr, w_data_wide[31:0], w_mask_wide[3:0]);
            w_beat1 = wr_beat(w_word_addr + 1'b1, w_data_wide[63:32], w_mask_wide[7:4]);
            w_two   = |w_mask_wide[7:4];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rrst_x) begin
            r_state     <= IDLE;
            o_req_valid <= 1'b0;
            r_two       <= 1'b0;
        end else begin
            o_req_valid <= 1'b0;
            case (r_state)
                IDLE: begin
                    if (w_accept) begin
                        o_req_valid <= 1'b1;
                        r_two       <= w_two;
                        r_state     <= i_rd_en ? RD_FIRST : WR_FIRST;
                    end
                end
                RD_FIRST, WR_FIRST: begin
                    if (w_next_beat) begin
                        o_req_valid <= 1'b1;
                        r_state     <= (r_state == RD_FIRST) ? RD_SECOND : WR_SECOND;
                    end else if (i_line_done) begin
                        r_state <= DONE;
                    end
                end
                RD_SECOND, WR_SECOND: begin
                    if (i_line_done)
                        r_state <= DONE;
                end
                default: r_state <= IDLE;
            endcase
        end
    end

    // beat payload and load context
    always_ff @(posedge i_clk) begin
        if (w_accept) begin
            o_req      <= w_beat0;
            r_req_next <= w_beat1;
            if (i_rd_en) begin
                o_ctx.off    <= i_addr[3:0];
                o_ctx.ctrl   <= i_ctrl;
                o_ctx.second <= w_two;
            end
        end else if (w_next_beat) begin
            o_req <= r_req_next;
        end
    end

endmodule

// File: hdl/line_cache.sv
// direct-mapped write-through line cache
// a hit is done 2 cycles after the request
// a miss takes 3 cycles including one store read
// a write goes to the store and invalidates the entry at that index
// accepts one request at a time, a new one only after o_line_done

`timescale 1ns/1ps

`include "mem_params.svh"

module line_cache (
    input  logic                CLK,
    input  logic                i_rrst_x,
    input  logic                i_req_valid,
    input  mem_pkg::line_req_t  i_req,
    input  mem_pkg::line_t      i_store_rdata,
    output logic                o_store_we,
    output mem_pkg::line_addr_t o_store_addr,
    output mem_pkg::line_t      o_store_wdata,
    output mem_pkg::line_mask_t o_store_mask,
    output logic                o_line_done,
    output mem_pkg::line_t      o_line
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(`MEM_CACHE_LINES);
    localparam int LA_W  = $bits(line_addr_t);
    localparam int TAG_W = LA_W - IDX_W;

    line_t                       data_mem [`MEM_CACHE_LINES];
    logic [TAG_W-1:0]            tag_mem  [`MEM_CACHE_LINES];
    logic [`MEM_CACHE_LINES-1:0] r_valid;
    line_req_t                   r_req;
    line_t                       r_data_q;
    logic [TAG_W-1:0]            r_tag_q;
    line_t                       r_line;
    logic                        r_lookup;
    logic                        r_fill;
    logic                        r_write;
    logic                        r_done;
    logic [IDX_W-1:0]            w_req_idx;
    logic [IDX_W-1:0]            w_idx;
    logic [TAG_W-1:0]            w_tag;
    logic                        w_hit;

    assign w_req_idx = i_req.addr[IDX_W-1:0];
    assign w_idx     = r_req.addr[IDX_W-1:0];
    assign w_tag     = r_req.addr[LA_W-1:IDX_W];
    assign w_hit     = r_valid[w_idx] && (r_tag_q == w_tag);

    // store always sees the latched request
    assign o_store_we    = r_write;
    assign o_store_addr  = r_req.addr;
    assign o_store_wdata = r_req.wdata;
    assign o_store_mask  = r_req.mask;
    assign o_line_done   = r_done;
    assign o_line        = r_line;

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_lookup <= 1'b0;
            r_fill   <= 1'b0;
            r_write  <= 1'b0;
            r_done   <= 1'b0;
            r_valid  <= '0;
        end else begin
            r_lookup <= i_req_valid && i_req.rd;
            r_write  <= i_req_valid && i_req.wr;
            r_fill   <= r_lookup && !w_hit;
            r_done   <= (r_lookup && w_hit) || r_fill || r_write;
            if (r_fill)
                r_valid[w_idx] <= 1'b1;
            else if (r_write)
                r_valid[w_idx] <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (i_req_valid) begin
            r_req    <= i_req;
            r_data_q <= data_mem[w_req_idx];
            r_tag_q  <= tag_mem[w_req_idx];
        end
        // fill from the store one cycle after the miss was seen
        if (r_fill) begin
            data_mem[w_idx] <= i_store_rdata;
            tag_mem[w_idx]  <= w_tag;
        end
        if (r_lookup)
            r_line <= r_data_q;
        else if (r_fill)
            r_line <= i_store_rdata;
    end

endmodule

// File: hdl/line_store.sv
// line RAM standing in for DRAM behind the cache
// single port, per-byte write enables, read data one cycle after the address
// a read in the write cycle returns the old contents
// only the low log2(MEM_STORE_LINES) line bits are decoded

`timescale 1ns/1ps

`include "mem_params.svh"

module line_store (
    input  logic                CLK,
    input  logic                i_we,
    input  mem_pkg::line_addr_t i_addr,
    input  mem_pkg::line_t      i_wdata,
    input  mem_pkg::line_mask_t i_mask,
    output mem_pkg::line_t      o_rdata
);
    import mem_pkg::*;

    localparam int AW = $clog2(`MEM_STORE_LINES);

    line_t         mem [`MEM_STORE_LINES];
    logic [AW-1:0] w_addr;

    assign w_addr = i_addr[AW-1:0];

    // starts zeroed like a cleared DRAM image
    initial begin
        for (int i = 0; i < `MEM_STORE_LINES; i++)
            mem[i] = '0;
    end

    always_ff @(posedge CLK) begin
        for (int b = 0; b < `MEM_LINE_BYTES; b++) begin
            if (i_we && i_mask[b])
                mem[w_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
        o_rdata <= mem[w_addr];
    end

endmodule

// File: hdl/load_aligner.sv
// builds the load result from one or two captured lines
// only the low 3 bytes of the second line can reach a 32-bit result
// o_rdata updates in the cycle after the last capture and holds until the next load
// i_ctx must stay stable from the first capture to the update

`timescale 1ns/1ps

`include "mem_params.svh"

module load_aligner (
    input  logic               CLK,
    input  logic               i_rrst_x,
    input  mem_pkg::line_t     i_line,
    input  logic               i_cap_first,
    input  logic               i_cap_second,
    input  mem_pkg::load_ctx_t i_ctx,
    output mem_pkg::word_t     o_rdata
);
    import mem_pkg::*;

    localparam int TAIL_W = `MEM_WORD_W - 8;

    line_t                         r_first;
    logic [TAIL_W-1:0]             r_second;
    logic                          r_pending;
    logic [`MEM_LINE_W+TAIL_W-1:0] w_cat;
    word_t                         w_word;
    word_t                         w_ext;

    always_comb begin
        // little-endian merge, then drop the bytes below the offset
        w_cat  = {r_second, r_first} >> {i_ctx.off, 3'b000};
        w_word = w_cat[`MEM_WORD_W-1:0];
        case (i_ctx.ctrl.size)
            SIZE_BYTE: w_ext = i_ctx.ctrl.is_unsigned ? {24'h000000, w_word[7:0]} :
                                                        {{24{w_word[7]}}, w_word[7:0]};
            SIZE_HALF: w_ext = i_ctx.ctrl.is_unsigned ? {16'h0000, w_word[15:0]} :
                                                        {{16{w_word[15]}}, w_word[15:0]};
            default:   w_ext = w_word;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (i_cap_first)
            r_first <= i_line;
        if (i_cap_second)
            r_second <= i_line[TAIL_W-1:0];
    end

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_pending <= 1'b0;
            o_rdata   <= '0;
        end else begin
            r_pending <= (i_cap_first && !i_ctx.second) || i_cap_second;
            if (r_pending)
                o_rdata <= w_ext;
        end
    end

endmodule

// File: hdl/mem_access_top.sv
// load/store front end built from sequencer, line cache, line store and load aligner
// user request/busy handshake, single clock, synchronous active-low reset
// hold i_rd_en or i_wr_en until o_busy is seen low at a rising edge

`timescale 1ns/1ps

module mem_access_top (
    input  logic               CLK,
    input  logic               i_rrst_x,
    input  logic               i_rd_en,
    input  logic               i_wr_en,
    input  mem_pkg::addr_t     i_addr,
    input  mem_pkg::word_t     i_wdata,
    input  mem_pkg::mem_ctrl_t i_ctrl,
    output mem_pkg::word_t     o_rdata,
    output logic               o_busy
);
    import mem_pkg::*;

    logic       w_req_valid;
    line_req_t  w_req;
    load_ctx_t  w_ctx;
    logic       w_cap_first;
    logic       w_cap_second;
    logic       w_line_done;
    line_t      w_line;
    logic       w_store_we;
    line_addr_t w_store_addr;
    line_t      w_store_wdata;
    line_mask_t w_store_mask;
    line_t      w_store_rdata;

    access_sequencer seq_i (
        .i_clk       (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_rd_en     (i_rd_en),
        .i_wr_en     (i_wr_en),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_ctrl      (i_ctrl),
        .i_line_done (w_line_done),
        .o_req_valid (w_req_valid),
        .o_req       (w_req),
        .o_ctx       (w_ctx),
        .o_cap_first (w_cap_first),
        .o_cap_second(w_cap_second),
        .o_busy      (o_busy)
    );

    line_cache cache_i (
        .CLK          (CLK),
        .i_rrst_x     (i_rrst_x),
        .i_req_valid  (w_req_valid),
        .i_req        (w_req),
        .i_store_rdata(w_store_rdata),
        .o_store_we   (w_store_we),
        .o_store_addr (w_store_addr),
        .o_store_wdata(w_store_wdata),
        .o_store_mask (w_store_mask),
        .o_line_done  (w_line_done),
        .o_line       (w_line)
    );

    line_store store_i (
        .CLK    (CLK),
        .i_we   (w_store_we),
        .i_addr (w_store_addr),
        .i_wdata(w_store_wdata),
        .i_mask (w_store_mask),
        .o_rdata(w_store_rdata)
    );

    load_aligner aligner_i (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_line      (w_line),
        .i_cap_first (w_cap_first),
        .i_cap_second(w_cap_second),
        .i_ctx       (w_ctx),
        .o_rdata     (o_rdata)
    );

endmodule

// File: verification/mem_properties.sv
// handshake and line request checks, bound into every access_sequencer
// o_busy may drop only in the cycle after the last o_line_done

`timescale 1ns/1ps

module mem_properties (
    input logic               i_clk,
    input logic               i_rrst_x,
    input logic               i_busy,
    input logic               i_line_done,
    input logic               i_req_valid,
    input mem_pkg::line_req_t i_req
);

    busy_held: assert property (@(posedge i_clk) disable iff (!i_rrst_x)
        i_busy && !i_line_done && !$past(i_line_done) |=> i_busy)
        else $error("o_busy fell before the line beat completed");

    // a beat is either a read or a write
    one_kind: assert property (@(posedge i_clk) disable iff (!i_rrst_x)
        i_req_valid |-> !(i_req.rd && i_req.wr))
        else $error("line request has both read and write set");

    write_mask: assert property (@(posedge i_clk) disable iff (!i_rrst_x)
        i_req_valid && i_req.wr |-> i_req.mask != '0)
        else $error("write line request with an empty byte mask");

endmodule

bind access_sequencer mem_properties props_i (
    .i_clk      (i_clk),
    .i_rrst_x   (i_rrst_x),
    .i_busy     (o_busy),
    .i_line_done(i_line_done),
    .i_req_valid(o_req_valid),
    .i_req      (o_req)
);

// File: verification/mem_checker.sv
// watches the user port and compares o_rdata after each load
// an access ends at the first edge that samples o_busy low after it was high
// i_peek compares o_rdata with i_exp while no access runs

`timescale 1ns/1ps

module mem_checker (
    input  logic           CLK,
    input  logic           i_rrst_x,
    input  logic           i_rd_en,
    input  logic           i_wr_en,
    input  mem_pkg::addr_t i_addr,
    input  mem_pkg::word_t i_exp,
    input  logic           i_peek,
    input  logic           i_report,
    input  logic           i_busy,
    input  mem_pkg::word_t i_rdata,
    output int             o_tests,
    output int             o_errors
);
    import mem_pkg::*;

    logic  r_busy_q;
    logic  r_load;
    addr_t r_addr;
    word_t r_exp;

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_busy_q <= 1'b0;
            o_tests  <= 0;
            o_errors <= 0;
        end else begin
            r_busy_q <= i_busy;
            // expected value travels with the accepted request
            if ((i_rd_en || i_wr_en) && !i_busy) begin
                r_load <= i_rd_en;
                r_addr <= i_addr;
                r_exp  <= i_exp;
            end
            if (r_busy_q && !i_busy) begin
                o_tests <= o_tests + 1;
                if (r_load && i_rdata !== r_exp) begin
                    $display("MISMATCH o_rdata test %0d addr %h: got %h expected %h",
                             o_tests, r_addr, i_rdata, r_exp);
                    o_errors <= o_errors + 1;
                end else begin
                    $display("test %0d %s at %h ok", o_tests, r_load ? "load" : "store",
                             r_addr);
                end
            end
            if (i_peek) begin
                o_tests <= o_tests + 1;
                if (i_rdata !== i_exp) begin
                    $display("MISMATCH o_rdata test %0d idle: got %h expected %h",
                             o_tests, i_rdata, i_exp);
                    o_errors <= o_errors + 1;
                end else begin
                    $display("test %0d idle o_rdata ok", o_tests);
                end
            end
            if (i_report)
                $display("tests %0d, passed %0d, failed %0d", o_tests, o_tests - o_errors,
                         o_errors);
        end
    end

endmodule

// File: verification/mem_tb.sv
// testbench for mem_access_top, one access at a time over the request/busy handshake
// reads verification/mem_tests.hex relative to the project root, five words per access
// op 0 compares o_rdata with no access, 1 loads, 2 stores, f ends the list

`timescale 1ns/1ps

module mem_tb;
    import mem_pkg::*;

    localparam int MAX_WORDS  = 320;
    localparam int WAIT_LIMIT = 64;

    logic        CLK = 1'b0;
    logic        rrst_x;
    logic        rd_en;
    logic        wr_en;
    addr_t       addr;
    word_t       wdata;
    mem_ctrl_t   ctrl;
    word_t       rdata;
    logic        busy;
    logic        peek;
    logic        report;
    word_t       exp_rdata;
    int          done_count;
    int          err_count;
    logic [31:0] tests [0:MAX_WORDS-1];

    always #50 CLK = ~CLK;

    mem_access_top dut_i (
        .CLK     (CLK),
        .i_rrst_x(rrst_x),
        .i_rd_en (rd_en),
        .i_wr_en (wr_en),
        .i_addr  (addr),
        .i_wdata (wdata),
        .i_ctrl  (ctrl),
        .o_rdata (rdata),
        .o_busy  (busy)
    );

    mem_checker chk_i (
        .CLK     (CLK),
        .i_rrst_x(rrst_x),
        .i_rd_en (rd_en),
        .i_wr_en (wr_en),
        .i_addr  (addr),
        .i_exp   (exp_rdata),
        .i_peek  (peek),
        .i_report(report),
        .i_busy  (busy),
        .i_rdata (rdata),
        .o_tests (done_count),
        .o_errors(err_count)
    );

    // o_busy is read right after the edge, before the DUT registers update
    task automatic wait_not_busy(input string what, output logic ok);
        int n;
        n = 0;
        do begin
            @(posedge CLK);
            n++;
        end while (busy && n < WAIT_LIMIT);
        ok = !busy;
        if (!ok)
            $display("timeout: o_busy still high %s after %0d cycles", what, n);
    endtask

    task automatic run_access(input logic [31:0] op, input logic [31:0] c,
                              input logic [31:0] a, input logic [31:0] d,
                              output logic ok);
        rd_en <= (op == 32'h1);
        wr_en <= (op == 32'h2);
        addr  <= a;
        wdata <= d;
        ctrl  <= mem_ctrl_t'(c[2:0]);
        // taken at the first edge that samples o_busy low
        wait_not_busy("before the request was taken", ok);
        rd_en <= 1'b0;
        wr_en <= 1'b0;
        if (ok)
            wait_not_busy("at the end of the access", ok);
    endtask

    initial begin
        int   i;
        int   n_tests;
        logic ok;
        rrst_x    = 1'b0;
        rd_en     = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        wdata     = '0;
        ctrl      = '0;
        peek      = 1'b0;
        report    = 1'b0;
        exp_rdata = '0;
        $readmemh("verification/mem_tests.hex", tests);
        repeat (5) @(posedge CLK);
        rrst_x <= 1'b1;
        i       = 0;
        n_tests = 0;
        ok      = 1'b1;
        while (ok && i < MAX_WORDS - 4 && tests[i] !== 32'hf) begin
            exp_rdata <= tests[i+4];
            if (tests[i] == 32'h0) begin
                peek <= 1'b1;
                @(posedge CLK);
                peek <= 1'b0;
            end else begin
                run_access(tests[i], tests[i+1], tests[i+2], tests[i+3], ok);
            end
            n_tests++;
            i += 5;
        end
        report <= 1'b1;
        @(posedge CLK);
        report <= 1'b0;
        @(posedge CLK);
        if (n_tests != done_count)
            $display("only %0d of %0d tests completed", done_count, n_tests);
        if (ok && n_tests == done_count && err_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: verification/mem_tests.hex
// op ctrl addr wdata expected; op 0 checks idle o_rdata, 1 load, 2 store, f ends
// ctrl {unsigned, size}: 0 byte, 1 half, 2 word, 4 unsigned byte, 5 unsigned half
0 0 00000000 00000000 00000000
2 2 00000010 80f17f92 00000000
1 2 00000010 00000000 80f17f92
1 0 00000010 00000000 ffffff92
1 4 00000010 00000000 00000092
1 0 00000011 00000000 0000007f
1 1 00000012 00000000 ffff80f1
1 5 00000012 00000000 000080f1
1 1 00000010 00000000 00007f92
2 2 00000020 33221100 00000000
2 2 00000024 77665544 00000000
2 1 00000023 ffffabcd 00000000
1 2 00000020 00000000 cd221100
1 2 00000024 00000000 776655ab
2 2 00000021 9a8b7c6d 00000000
1 2 00000020 00000000 8b7c6d00
1 2 00000024 00000000 7766559a
2 2 00000026 44332211 00000000
1 2 00000024 00000000 2211559a
1 2 00000028 00000000 00004433
2 2 0000003c d4c3b2a1 00000000
2 2 00000040 48372615 00000000
1 2 0000003d 00000000 15d4c3b2
1 2 0000003e 00000000 2615d4c3
1 2 0000003f 00000000 372615d4
2 1 0000003f 0000e0f0 00000000
1 2 0000003d 00000000 e0f0c3b2
1 2 00000040 00000000 483726e0
2 0 00000011 ffffff55 00000000
1 2 00000010 00000000 80f15592
1 2 00000010 00000000 80f15592
1 2 00000410 00000000 00000000
1 2 00000010 00000000 80f15592
f 0 00000000 00000000 00000000

// File: verilog.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/access_sequencer.sv
hdl/line_cache.sv
hdl/line_store.sv
hdl/load_aligner.sv
hdl/mem_access_top.sv
verification/mem_properties.sv
verification/mem_checker.sv
verification/mem_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module mem_tb -o mem_tb
out=$(./obj_dir/mem_tb)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'NO ERRORS'
